// File: flist.f
hw/ssc_pkg.sv
hw/wipe_ctrl_if.sv
hw/wipe_addr_seq.sv
hw/ssc_fault_monitor.sv
hw/start_stop_fsm.sv
hw/start_stop_ctrl.sv
verif/tb_clock_gen.sv
verif/tb_start_stop_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_start_stop_ctrl -f flist.f \
  && ./obj_dir/Vtb_start_stop_ctrl | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verif/tb_start_stop_ctrl.sv
// Testbench for the start/stop controller with URND and controller responders
// A monitor counts wipe events per round and checks lock, RMA and fatal state
`timescale 1ns/1ps

module tb_start_stop_ctrl;
  import ssc_pkg::*;

  localparam int NumRuns       = 4;
  // Boot wipes of four resets, two rounds per run, escalation and RMA wipes
  localparam int TestRounds    = 8 + 2 * NumRuns + 4;
  localparam int TimeoutCycles = TestRounds * 200 + 1000;

  logic       clk;
  logic       rst_n;
  logic       rst_req;
  logic       start;
  mubi4_t     escalate_en;
  mubi4_t     rma_req;
  mubi4_t     rma_ack;
  logic       ctrl_start;
  logic       urnd_req;
  logic       urnd_ack;
  logic       urnd_adv;
  logic       wipe_req;
  logic       wipe_ack;
  logic       wipe_running;
  logic       done;
  logic       wdr;
  logic       wdr_urnd;
  logic       base;
  logic       base_urnd;
  wipe_addr_t waddr;
  logic       acc_urnd;
  logic       mod_urnd;
  logic       wzero;
  logic       ispr_init;
  logic       state_reset;
  logic       fatal;

  integer seed = 32'h6b5a4f05;
  int     err_cnt;
  int     check_cnt;
  // Per-round event counts, cleared at each zero pulse
  int     wdr_cnt;
  int     acc_cnt;
  int     mod_cnt;
  int     base_cnt;
  int     boot_rounds;
  // Running totals of pulses over the whole run
  int     round_cnt;
  int     ispr_cnt;
  int     sreset_cnt;
  int     cstart_cnt;
  int     done_cnt;
  int     wack_cnt;
  // Model state, set by the sequence where the rules say the DUT changes
  logic   ctrl_en;
  logic   locked_exp;
  logic   fatal_exp;
  mubi4_t rma_ack_exp;

  tb_clock_gen u_clock_gen (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .rst_no    (rst_n)
  );

  start_stop_ctrl uut (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .start_i               (start),
    .escalate_en_i         (escalate_en),
    .rma_req_i             (rma_req),
    .rma_ack_o             (rma_ack),
    .controller_start_o    (ctrl_start),
    .urnd_reseed_req_o     (urnd_req),
    .urnd_reseed_ack_i     (urnd_ack),
    .urnd_advance_o        (urnd_adv),
    .secure_wipe_req_i     (wipe_req),
    .secure_wipe_ack_o     (wipe_ack),
    .secure_wipe_running_o (wipe_running),
    .done_o                (done),
    .sec_wipe_wdr_o        (wdr),
    .sec_wipe_wdr_urnd_o   (wdr_urnd),
    .sec_wipe_base_o       (base),
    .sec_wipe_base_urnd_o  (base_urnd),
    .sec_wipe_addr_o       (waddr),
    .sec_wipe_acc_urnd_o   (acc_urnd),
    .sec_wipe_mod_urnd_o   (mod_urnd),
    .sec_wipe_zero_o       (wzero),
    .ispr_init_o           (ispr_init),
    .state_reset_o         (state_reset),
    .fatal_error_o         (fatal)
  );

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got == exp) else begin
      err_cnt++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_cnt++;
    assert (cond) else begin
      err_cnt++;
      $display("Check failed at %0t: %s", $time, what);
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
  endtask

  task automatic wait_zero_pulses(input int n);
    repeat (n) begin
      do @(negedge clk); while (!wzero);
    end
  endtask

  task automatic wait_done();
    do @(negedge clk); while (!done);
  endtask

  // First cycle after reset is Initial with a pending reseed
  task automatic check_reset_values();
    @(posedge rst_n);
    @(negedge clk);
    check_val("urnd_reseed_req_o", urnd_req, 1);
    check_val("secure_wipe_running_o", wipe_running, 1);
    check_val("controller_start_o", ctrl_start, 0);
    check_val("urnd_advance_o", urnd_adv, 0);
    check_val("done_o", done, 0);
    check_val("secure_wipe_ack_o", wipe_ack, 0);
  endtask

  task automatic apply_reset();
    escalate_en = MuBi4False;
    rma_req     = MuBi4False;
    start       = 1'b0;
    wipe_req    = 1'b0;
    locked_exp  = 1'b0;
    fatal_exp   = 1'b0;
    rma_ack_exp = MuBi4False;
    rst_req     = 1'b1;
    next_cycle();
    rst_req     = 1'b0;
    check_reset_values();
  endtask

  // Boot runs two full rounds and never reports done
  task automatic wait_boot();
    int done_before;
    done_before = done_cnt;
    wait_zero_pulses(2);
    repeat (3) next_cycle();
    check_val("done_o pulses in boot", done_cnt - done_before, 0);
  endtask

  // URND source acknowledges each request after 1 to 8 cycles
  initial begin
    int delay;
    forever begin
      @(negedge clk);
      if (rst_n && urnd_req) begin
        delay = 1 + ($unsigned($random(seed)) % 8);
        repeat (delay) @(posedge clk);
        #2 urnd_ack = 1'b1;
        @(posedge clk);
        #2 urnd_ack = 1'b0;
      end
    end
  end

  // Controller model, asks for a stop a while after it was started
  initial begin
    int delay;
    forever begin
      @(negedge clk);
      if (rst_n && ctrl_en && ctrl_start) begin
        delay = 1 + ($unsigned($random(seed)) % 10);
        repeat (delay) @(posedge clk);
        #2 wipe_req = 1'b1;
        // Request is held until the acknowledge and dropped right after it
        do @(negedge clk); while (!wipe_ack);
        @(posedge clk);
        #2 wipe_req = 1'b0;
      end
    end
  end

  // Mid-cycle monitor with the per-round wipe model
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      wdr_cnt     = 0;
      acc_cnt     = 0;
      mod_cnt     = 0;
      base_cnt    = 0;
      boot_rounds = 0;
    end else begin
      check_val("sec_wipe_wdr_urnd_o", wdr_urnd, wdr);
      check_val("sec_wipe_base_urnd_o", base_urnd, base);
      // Wide registers are written in order from address 0
      if (wdr) begin
        check_val("sec_wipe_addr_o", waddr, wdr_cnt);
        wdr_cnt++;
      end
      // Base writes skip the zero register and the call stack
      if (base) begin
        check_val("sec_wipe_addr_o", waddr, base_cnt + 2);
        base_cnt++;
      end
      if (acc_urnd) begin
        acc_cnt++;
      end
      if (mod_urnd) begin
        mod_cnt++;
      end
      // Every random wipe write consumes URND data and needs the source to advance
      if (wdr_urnd || base_urnd || acc_urnd || mod_urnd) begin
        check_true(urnd_adv, "urnd_advance_o low during a random wipe write");
      end
      if (boot_rounds < 2) begin
        check_true(wipe_running, "secure_wipe_running_o dropped during the boot wipe");
      end
      // The zero cycle closes a round
      if (wzero) begin
        check_val("sec_wipe_wdr_o count", wdr_cnt, 32);
        check_val("sec_wipe_acc_urnd_o count", acc_cnt, 1);
        check_val("sec_wipe_mod_urnd_o count", mod_cnt, 1);
        check_val("sec_wipe_base_o count", base_cnt, 30);
        wdr_cnt  = 0;
        acc_cnt  = 0;
        mod_cnt  = 0;
        base_cnt = 0;
        round_cnt++;
        if (boot_rounds < 2) begin
          boot_rounds++;
        end
      end
      if (ispr_init) begin
        ispr_cnt++;
        check_true(state_reset && urnd_req, "ispr_init_o came without state reset and reseed");
      end
      if (state_reset) begin
        sreset_cnt++;
      end
      if (ctrl_start) begin
        cstart_cnt++;
        check_true(urnd_ack, "controller_start_o outside the reseed acknowledge cycle");
      end
      if (done) begin
        done_cnt++;
      end
      if (wipe_ack) begin
        wack_cnt++;
      end
      if (locked_exp) begin
        check_true(!ctrl_start && !urnd_req && !urnd_adv,
                   "locked controller started, asked for a reseed or advanced URND");
      end
      check_val("rma_ack_o", rma_ack, rma_ack_exp);
      if (!fatal_exp) begin
        check_val("fatal_error_o", fatal, 0);
      end
    end
  end

  initial begin
    int     r0;
    int     i0;
    int     s0;
    int     c0;
    int     a0;
    int     d0;
    int     delay;
    mubi4_t bad_code;

    start       = 1'b0;
    escalate_en = MuBi4False;
    rma_req     = MuBi4False;
    urnd_ack    = 1'b0;
    wipe_req    = 1'b0;
    rst_req     = 1'b0;
    ctrl_en     = 1'b1;
    locked_exp  = 1'b0;
    fatal_exp   = 1'b0;
    rma_ack_exp = MuBi4False;
    err_cnt     = 0;
    check_cnt   = 0;
    round_cnt   = 0;
    ispr_cnt    = 0;
    sreset_cnt  = 0;
    cstart_cnt  = 0;
    done_cnt    = 0;
    wack_cnt    = 0;

    check_reset_values();
    wait_boot();

    // Repeated start, run and controller stop
    for (int i = 0; i < NumRuns; i++) begin
      r0 = round_cnt;
      i0 = ispr_cnt;
      s0 = sreset_cnt;
      c0 = cstart_cnt;
      a0 = wack_cnt;
      d0 = done_cnt;
      pulse_start();
      wait_done();
      next_cycle();
      check_val("ispr_init_o pulses", ispr_cnt - i0, 1);
      check_val("state_reset_o pulses", sreset_cnt - s0, 1);
      check_val("controller_start_o pulses", cstart_cnt - c0, 1);
      check_val("secure_wipe_ack_o pulses", wack_cnt - a0, 1);
      check_val("done_o pulses", done_cnt - d0, 1);
      check_val("sec_wipe_zero_o pulses", round_cnt - r0, 2);
      repeat (2) next_cycle();
    end

    // Escalation at a random point of a run, with the controller silent
    ctrl_en = 1'b0;
    r0 = round_cnt;
    c0 = cstart_cnt;
    pulse_start();
    do @(negedge clk); while (!ctrl_start);
    delay = 1 + ($unsigned($random(seed)) % 10);
    repeat (delay) next_cycle();
    escalate_en = MuBi4True;
    wait_done();
    next_cycle();
    locked_exp = 1'b1;
    check_val("sec_wipe_zero_o pulses", round_cnt - r0, 2);
    repeat (3) begin
      pulse_start();
      repeat (4) next_cycle();
    end
    check_val("controller_start_o pulses", cstart_cnt - c0, 1);

    // RMA from Halt reseeds, wipes twice, acknowledges and locks
    apply_reset();
    wait_boot();
    r0 = round_cnt;
    c0 = cstart_cnt;
    rma_req = MuBi4True;
    wait_done();
    next_cycle();
    rma_ack_exp = MuBi4True;
    locked_exp  = 1'b1;
    check_val("sec_wipe_zero_o pulses", round_cnt - r0, 2);
    pulse_start();
    repeat (4) next_cycle();
    check_val("controller_start_o pulses", cstart_cnt - c0, 0);

    // Invalid escalate code gives one done pulse and a sticky fatal error
    apply_reset();
    wait_boot();
    d0 = done_cnt;
    do bad_code = 4'($random(seed)); while (bad_code == MuBi4True || bad_code == MuBi4False);
    escalate_en = bad_code;
    fatal_exp   = 1'b1;
    @(negedge clk);
    check_val("done_o", done, 0);
    check_val("fatal_error_o", fatal, 0);
    @(negedge clk);
    check_val("done_o", done, 1);
    check_val("fatal_error_o", fatal, 1);
    repeat (6) begin
      @(negedge clk);
      check_val("fatal_error_o", fatal, 1);
    end
    next_cycle();
    check_val("done_o pulses", done_cnt - d0, 1);

    // Wipe request while halted counts as a protocol error
    apply_reset();
    wait_boot();
    wipe_req  = 1'b1;
    fatal_exp = 1'b1;
    @(negedge clk);
    check_val("fatal_error_o", fatal, 0);
    next_cycle();
    wipe_req = 1'b0;
    repeat (5) begin
      @(negedge clk);
      check_val("fatal_error_o", fatal, 1);
    end
    next_cycle();

    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog sized from the number of wipe rounds in the sequence
  initial begin
    #(TimeoutCycles * 40);
    $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("Something failed");
    $finish;
  end

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and reset source
// 40 ns clock, three-cycle active-low reset at start and on each request
`timescale 1ns/1ps

module tb_clock_gen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset covers three rising edges and lifts 2 ns after the third one
  always begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    #2 rst_no = 1'b1;
    @(posedge rst_req_i);
  end

endmodule

// File: hw/start_stop_ctrl.sv
// Top level of the start/stop controller
// Ties the FSM, the wipe address sequencer and the fault monitor to plain ports
`timescale 1ns/1ps

module start_stop_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  ssc_pkg::mubi4_t     escalate_en_i,
  input  ssc_pkg::mubi4_t     rma_req_i,
  output ssc_pkg::mubi4_t     rma_ack_o,
  output logic                controller_start_o,
  output logic                urnd_reseed_req_o,
  input  logic                urnd_reseed_ack_i,
  output logic                urnd_advance_o,
  input  logic                secure_wipe_req_i,
  output logic                secure_wipe_ack_o,
  output logic                secure_wipe_running_o,
  output logic                done_o,
  output logic                sec_wipe_wdr_o,
  output logic                sec_wipe_wdr_urnd_o,
  output logic                sec_wipe_base_o,
  output logic                sec_wipe_base_urnd_o,
  output ssc_pkg::wipe_addr_t sec_wipe_addr_o,
  output logic                sec_wipe_acc_urnd_o,
  output logic                sec_wipe_mod_urnd_o,
  output logic                sec_wipe_zero_o,
  output logic                ispr_init_o,
  output logic                state_reset_o,
  output logic                fatal_error_o
);

  // Decoded lifecycle requests from the monitor
  logic esc_req;
  logic rma_req;
  logic input_invalid;
  logic mubi_err_new;
  // Status the FSM reports back for the protocol and error checks
  logic done_stop;
  logic allow_wipe;
  logic expect_wipe;
  logic init_wipe_done;
  logic state_error;
  logic internal_invalid;

  wipe_ctrl_if wipe ();

  wipe_addr_seq u_wipe_addr_seq (
    .clk_i,
    .rst_ni,
    .wipe                 (wipe),
    .sec_wipe_addr_o,
    .sec_wipe_wdr_o,
    .sec_wipe_wdr_urnd_o,
    .sec_wipe_base_o,
    .sec_wipe_base_urnd_o,
    .sec_wipe_acc_urnd_o,
    .sec_wipe_mod_urnd_o
  );

  ssc_fault_monitor u_fault_monitor (
    .clk_i,
    .rst_ni,
    .escalate_en_i,
    .rma_req_i,
    .secure_wipe_req_i,
    .allow_wipe,
    .expect_wipe,
    .init_wipe_done,
    .state_error,
    .internal_invalid,
    .esc_req,
    .rma_req,
    .input_invalid,
    .mubi_err_new,
    .fatal_error_o
  );

  start_stop_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .start_i,
    .rma_req_i,
    .esc_req,
    .rma_req,
    .input_invalid,
    .urnd_reseed_ack_i,
    .secure_wipe_req_i,
    .wipe                  (wipe),
    .rma_ack_o,
    .controller_start_o,
    .urnd_reseed_req_o,
    .urnd_advance_o,
    .secure_wipe_ack_o,
    .secure_wipe_running_o,
    .sec_wipe_zero_o,
    .ispr_init_o,
    .state_reset_o,
    .done_stop,
    .allow_wipe,
    .expect_wipe,
    .init_wipe_done,
    .state_error,
    .internal_invalid
  );

  // Done after a normal stop, and once when a multi-bit error first shows up
  assign done_o = done_stop | mubi_err_new;

endmodule

// File: hw/start_stop_fsm.sv
// Main start/stop FSM with lock handling and RMA acknowledge
// Sequences URND reseeds and the two-round secure wipe
`timescale 1ns/1ps

module start_stop_fsm (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  ssc_pkg::mubi4_t rma_req_i,
  input  logic            esc_req,
  input  logic            rma_req,
  input  logic            input_invalid,
  input  logic            urnd_reseed_ack_i,
  input  logic            secure_wipe_req_i,
  wipe_ctrl_if.fsm        wipe,
  output ssc_pkg::mubi4_t rma_ack_o,
  output logic            controller_start_o,
  output logic            urnd_reseed_req_o,
  output logic            urnd_advance_o,
  output logic            secure_wipe_ack_o,
  output logic            secure_wipe_running_o,
  output logic            sec_wipe_zero_o,
  output logic            ispr_init_o,
  output logic            state_reset_o,
  output logic            done_stop,
  output logic            allow_wipe,
  output logic            expect_wipe,
  output logic            init_wipe_done,
  output logic            state_error,
  output logic            internal_invalid
);
  import ssc_pkg::*;

  ssc_state_e state_q, state_d;
  mubi4_t     wipe_round_q, wipe_round_d;
  mubi4_t     rma_ack_q, rma_ack_d;
  logic       should_lock_q, should_lock_d;
  logic       init_wipe_done_q, init_wipe_done_d;
  logic       state_error_q, state_error_d;
  logic       ctrl_wipe_q, ctrl_wipe_d;
  logic       stop;
  logic       first_round;
  logic       in_wipe;

  // The controller, escalation and lifecycle can each ask for a stop
  assign stop = esc_req | rma_req | secure_wipe_req_i;

  // Escalation and RMA are remembered so the FSM locks once the wipe is done
  assign should_lock_d = should_lock_q | esc_req | rma_req;

  // Low round flag means the next wipe round is the first one
  assign first_round = mubi4_false_strict(wipe_round_q);

  assign internal_invalid = mubi4_invalid(wipe_round_q) | mubi4_invalid(rma_ack_q);

  always_comb begin
    state_d               = state_q;
    wipe_round_d          = wipe_round_q;
    rma_ack_d             = rma_ack_q;
    state_error_d         = state_error_q;
    ctrl_wipe_d           = ctrl_wipe_q;
    wipe.phase            = Idle;
    wipe.cnt_run          = 1'b0;
    controller_start_o    = 1'b0;
    urnd_reseed_req_o     = 1'b0;
    urnd_advance_o        = 1'b0;
    secure_wipe_ack_o     = 1'b0;
    secure_wipe_running_o = 1'b0;
    sec_wipe_zero_o       = 1'b0;
    ispr_init_o           = 1'b0;
    state_reset_o         = 1'b0;
    done_stop             = 1'b0;
    allow_wipe            = 1'b0;
    in_wipe               = 1'b0;

    case (state_q)
      Initial: begin
        // Boot seeds URND first and then wipes both register files
        secure_wipe_running_o = 1'b1;
        urnd_reseed_req_o     = 1'b1;
        if (urnd_reseed_ack_i) begin
          urnd_advance_o = 1'b1;
          state_d        = WipeWdr;
        end
      end
      Halt: begin
        // A stop without RMA while idle locks right away
        if (stop && !rma_req) begin
          state_d = Locked;
        end else if (start_i || rma_req) begin
          urnd_reseed_req_o = 1'b1;
          ispr_init_o       = 1'b1;
          state_reset_o     = 1'b1;
          state_d           = UrndRefresh;
        end
      end
      UrndRefresh: begin
        urnd_reseed_req_o = 1'b1;
        if (first_round && !(stop && rma_req) && stop) begin
          // Stop before anything ran, so nothing needs wiping
          done_stop = 1'b1;
          state_d   = Locked;
        end else if (first_round && !stop) begin
          // Reseed ahead of a run, the controller starts in the ack cycle
          if (urnd_reseed_ack_i) begin
            controller_start_o = 1'b1;
            state_d            = Running;
          end
        end else begin
          // Reseed between wipe rounds or ahead of an RMA wipe
          allow_wipe            = 1'b1;
          in_wipe               = 1'b1;
          secure_wipe_running_o = 1'b1;
          if (urnd_reseed_ack_i) begin
            state_d = WipeWdr;
          end
        end
      end
      Running: begin
        urnd_advance_o = 1'b1;
        allow_wipe     = 1'b1;
        if (stop) begin
          // Only a wipe the controller asked for must be held until the ack
          ctrl_wipe_d = secure_wipe_req_i;
          state_d     = WipeWdr;
        end
      end
      WipeWdr: begin
        urnd_advance_o        = 1'b1;
        allow_wipe            = 1'b1;
        in_wipe               = 1'b1;
        secure_wipe_running_o = 1'b1;
        wipe.phase            = Wdr;
        // Stop counting at the last count so the next phase starts from zero
        wipe.cnt_run          = ~wipe.wdr_last;
        if (wipe.wdr_last) begin
          state_d = WipeAccModBase;
        end
      end
      WipeAccModBase: begin
        urnd_advance_o        = 1'b1;
        allow_wipe            = 1'b1;
        in_wipe               = 1'b1;
        secure_wipe_running_o = 1'b1;
        wipe.phase            = AccModBase;
        wipe.cnt_run          = ~wipe.base_last;
        if (wipe.base_last) begin
          state_d = WipeZero;
        end
      end
      WipeZero: begin
        // One cycle clears the CSRs and the stack
        sec_wipe_zero_o       = 1'b1;
        allow_wipe            = 1'b1;
        in_wipe               = 1'b1;
        secure_wipe_running_o = 1'b1;
        wipe.phase            = Zero;
        if (first_round) begin
          // Fresh URND and then the second random round
          wipe_round_d = MuBi4True;
          state_d      = UrndRefresh;
        end else begin
          secure_wipe_ack_o = 1'b1;
          state_d           = WipeComplete;
        end
      end
      WipeComplete: begin
        urnd_advance_o = 1'b1;
        rma_ack_d      = rma_req_i;
        wipe_round_d   = MuBi4False;
        ctrl_wipe_d    = 1'b0;
        done_stop      = init_wipe_done_q;
        state_d        = should_lock_d ? Locked : Halt;
      end
      Locked: begin
        // Terminal state, only a reset leaves it
      end
      default: begin
        // Illegal code, most likely a fault on the state register
        state_error_d = 1'b1;
        rma_ack_d     = MuBi4False;
        state_d       = Locked;
      end
    endcase

    // Bad multi-bit values lock the FSM and internal ones go back to a safe code
    if (input_invalid) begin
      state_d = Locked;
    end
    if (mubi4_invalid(wipe_round_q)) begin
      wipe_round_d = MuBi4False;
      state_d      = Locked;
    end
    if (mubi4_invalid(rma_ack_q)) begin
      rma_ack_d = MuBi4False;
      state_d   = Locked;
    end
  end

  // Boot wipe is done once WipeComplete has been seen
  assign init_wipe_done_d = init_wipe_done_q | (state_q == WipeComplete);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q          <= Initial;
      wipe_round_q     <= MuBi4False;
      rma_ack_q        <= MuBi4False;
      should_lock_q    <= 1'b0;
      init_wipe_done_q <= 1'b0;
      state_error_q    <= 1'b0;
      ctrl_wipe_q      <= 1'b0;
    end else begin
      state_q          <= state_d;
      wipe_round_q     <= wipe_round_d;
      rma_ack_q        <= rma_ack_d;
      should_lock_q    <= should_lock_d;
      init_wipe_done_q <= init_wipe_done_d;
      state_error_q    <= state_error_d;
      ctrl_wipe_q      <= ctrl_wipe_d;
    end
  end

  assign expect_wipe    = in_wipe & ctrl_wipe_q;
  assign init_wipe_done = init_wipe_done_q;
  assign state_error    = state_error_d;
  assign rma_ack_o      = rma_ack_q;

endmodule

// File: hw/ssc_fault_monitor.sv
// Lifecycle input decode, multi-bit validity and wipe-request protocol checks
// Collects every error source into the sticky fatal error
`timescale 1ns/1ps

module ssc_fault_monitor (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  ssc_pkg::mubi4_t escalate_en_i,
  input  ssc_pkg::mubi4_t rma_req_i,
  input  logic            secure_wipe_req_i,
  input  logic            allow_wipe,
  input  logic            expect_wipe,
  input  logic            init_wipe_done,
  input  logic            state_error,
  input  logic            internal_invalid,
  output logic            esc_req,
  output logic            rma_req,
  output logic            input_invalid,
  output logic            mubi_err_new,
  output logic            fatal_error_o
);
  import ssc_pkg::*;

  logic spurious_wipe_req;
  logic dropped_wipe_req;
  logic wipe_err_q;
  logic mubi_err_d, mubi_err_q;
  logic mubi_err_new_q;
  logic fatal_q;

  // Escalation fails safe, so any code other than false stops the engine
  assign esc_req = mubi4_true_loose(escalate_en_i);
  // RMA has lasting effects and only acts on the exact true code
  assign rma_req = mubi4_true_strict(rma_req_i);

  assign input_invalid = mubi4_invalid(escalate_en_i) | mubi4_invalid(rma_req_i);

  // The controller may only request a wipe while the FSM allows one
  assign spurious_wipe_req = secure_wipe_req_i & ~allow_wipe;

  // Once a controller wipe is under way the request has to stay up until the ack
  // The boot wipe is driven from inside and is exempt
  assign dropped_wipe_req = expect_wipe & init_wipe_done & ~secure_wipe_req_i;

  // Any invalid encoding, external or internal, sets the sticky multi-bit error
  assign mubi_err_d = mubi_err_q | input_invalid | internal_invalid;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wipe_err_q     <= 1'b0;
      mubi_err_q     <= 1'b0;
      mubi_err_new_q <= 1'b0;
      fatal_q        <= 1'b0;
    end else begin
      // Protocol errors are delayed a cycle to break the path back into the controller
      wipe_err_q     <= spurious_wipe_req | dropped_wipe_req;
      mubi_err_q     <= mubi_err_d;
      // One-cycle pulse when the multi-bit error first appears
      mubi_err_new_q <= mubi_err_d & ~mubi_err_q;
      fatal_q        <= fatal_error_o;
    end
  end

  assign mubi_err_new = mubi_err_new_q;

  // State errors show up at once, the rest one cycle after they occur
  assign fatal_error_o = fatal_q | wipe_err_q | mubi_err_q | state_error;

endmodule

// File: hw/wipe_addr_seq.sv
// Wipe address counter with end-of-phase flags
// Decodes the per-register-file wipe enables from phase and count
`timescale 1ns/1ps

module wipe_addr_seq (
  input  logic                clk_i,
  input  logic                rst_ni,
  wipe_ctrl_if.seq            wipe,
  output ssc_pkg::wipe_addr_t sec_wipe_addr_o,
  output logic                sec_wipe_wdr_o,
  output logic                sec_wipe_wdr_urnd_o,
  output logic                sec_wipe_base_o,
  output logic                sec_wipe_base_urnd_o,
  output logic                sec_wipe_acc_urnd_o,
  output logic                sec_wipe_mod_urnd_o
);
  import ssc_pkg::*;

  wipe_cnt_t cnt_q, cnt_d;
  logic      in_wdr;
  logic      in_amb;

  assign in_wdr = (wipe.phase == Wdr);
  assign in_amb = (wipe.phase == AccModBase);

  // Count while the FSM asks for it, otherwise fall back to zero
  assign cnt_d = wipe.cnt_run ? (cnt_q + 6'd1) : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // End-of-phase flags for the FSM
  assign wipe.wdr_last  = in_wdr & (cnt_q == WdrLastCnt);
  assign wipe.base_last = in_amb & (cnt_q == BaseLastCnt);

  // The counter never enables a write above 31 so the top bit can be dropped
  assign sec_wipe_addr_o = cnt_q[4:0];

  // WDR enables are flopped once downstream
  // They drop at the extra count so the last WDR and the accumulator get different data
  assign sec_wipe_wdr_o      = in_wdr & (cnt_q < WipeRegs);
  assign sec_wipe_wdr_urnd_o = in_wdr & (cnt_q < WipeRegs);

  // First two counts of the second phase go to accumulator and modulus
  assign sec_wipe_acc_urnd_o = in_amb & (cnt_q == 6'd0);
  assign sec_wipe_mod_urnd_o = in_amb & (cnt_q == 6'd1);

  // Addresses 0 and 1 are the zero register and the call stack
  // Those two are never written with random data
  assign sec_wipe_base_o      = in_amb & (cnt_q > 6'd1);
  assign sec_wipe_base_urnd_o = in_amb & (cnt_q > 6'd1);

endmodule

// File: hw/wipe_ctrl_if.sv
// Control link between the start/stop FSM and the wipe address sequencer
`timescale 1ns/1ps

interface wipe_ctrl_if;
  import ssc_pkg::*;

  // Wipe phase decoded from the FSM state
  wipe_phase_e phase;
  // Counter runs while high and clears on the next edge when low
  logic        cnt_run;
  // Last count of the wide-register phase
  logic        wdr_last;
  // Last count of the accumulator/modulus/base phase
  logic        base_last;

  // The FSM owns the phase and the counter enable
  modport fsm (
    output phase,
    output cnt_run,
    input  wdr_last,
    input  base_last
  );

  // The sequencer owns the end-of-phase flags
  modport seq (
    input  phase,
    input  cnt_run,
    output wdr_last,
    output base_last
  );

endinterface

// File: hw/ssc_pkg.sv
// Shared types, constants and encodings of the start/stop controller
// Also holds the multi-bit boolean check functions
package ssc_pkg;

  // Four-bit multi-bit boolean where only two of the sixteen codes are valid
  typedef logic [3:0] mubi4_t;

  localparam mubi4_t MuBi4True  = 4'h6;
  localparam mubi4_t MuBi4False = 4'h9;

  // Register-file address and the wipe counter that runs one past it
  typedef logic [4:0] wipe_addr_t;
  typedef logic [5:0] wipe_cnt_t;

  // Registers per file, for both the wide and the base register file
  localparam wipe_cnt_t WipeRegs    = 6'd32;
  // The wide phase counts one extra cycle for the flop behind the WDR enables
  localparam wipe_cnt_t WdrLastCnt  = 6'd32;
  localparam wipe_cnt_t BaseLastCnt = 6'd31;

  // Sparse-ish state codes so that a flipped bit tends to land on an illegal code
  typedef enum logic [3:0] {
    Initial        = 4'h3,
    Halt           = 4'h5,
    UrndRefresh    = 4'h6,
    Running        = 4'h9,
    WipeWdr        = 4'ha,
    WipeAccModBase = 4'hc,
    WipeZero       = 4'hf,
    WipeComplete   = 4'h0,
    Locked         = 4'he
  } ssc_state_e;

  typedef enum logic [1:0] {
    Idle,
    Wdr,
    AccModBase,
    Zero
  } wipe_phase_e;

  function automatic logic mubi4_invalid(mubi4_t val);
    return !((val == MuBi4True) || (val == MuBi4False));
  endfunction

  // Strict test, only the exact true code counts
  function automatic logic mubi4_true_strict(mubi4_t val);
    return (val == MuBi4True);
  endfunction

  // Loose test, anything that is not the false code counts as true
  function automatic logic mubi4_true_loose(mubi4_t val);
    return (val != MuBi4False);
  endfunction

  function automatic logic mubi4_false_strict(mubi4_t val);
    return (val == MuBi4False);
  endfunction

endpackage
